// File: sim.f
+incdir+include
hdl/isaPkg.sv
hdl/busPkg.sv
hdl/phaseSequencer.sv
hdl/instructionDecoder.sv
hdl/registerFile.sv
hdl/aluUnit.sv
hdl/core.sv
test/clockGen.sv
test/core_sva.sv
test/coreInstructionTests.sv

// File: test/instruction_cases.txt
# kind, instruction word, extra word, expected address, expected data, name
# values in hex; extra is the HERE literal or the LD data, address is PC+2 for HERE
here 4800 faaf 0002 0000 ldHereR0
st   5000 0000 faaf faaf stR0Here
alu  00af 0000 0000 0000 movRaS8
st   50f0 0000 faaf ffaf stRaS8
alu  01fa 0000 0000 0000 movRaU8
st   50f0 0000 faaf 00fa stRaU8
alu  0211 0000 0000 0000 movR1U4
alu  0223 0000 0000 0000 movR2U4
alu  0235 0000 0000 0000 movR3U4
alu  0247 0000 0000 0000 movR4U4
st   5010 0000 faaf 0001 stR1U4
st   5020 0000 faaf 0003 stR2U4
st   5030 0000 faaf 0005 stR3U4
st   5040 0000 faaf 0007 stR4U4
alu  0712 0000 0000 0000 addR1R2
st   5010 0000 faaf 0004 stAddResult
alu  0b34 0000 0000 0000 subR3R4
st   5030 0000 faaf fffe stSubResult
alu  0d0f 0000 0000 0000 andRaU8
st   50f0 0000 faaf 000a stAndResult
alu  1249 0000 0000 0000 orR4U4
st   5040 0000 faaf 000f stOrResult
alu  1724 0000 0000 0000 xorR2R4
st   5020 0000 faaf 000c stXorResult
ld   4050 1234 faaf 0000 ldR5
st   5050 0000 faaf 1234 stLoadResult
nop  8354 0000 0000 0000 nopReserved
st   5050 0000 faaf 1234 stAfterNop

// File: test/coreInstructionTests.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module coreInstructionTests;

	localparam int dataWidth = `CORE_DATA_WIDTH;
	localparam int driveDelay = 5; // ns after the rising edge.
	localparam int resetCycles = 10;
	localparam int waitLimit = 16; // cycles allowed per wait.
	localparam int waitFetch = 0;
	localparam int waitRead = 1;
	localparam int waitWrite = 2;

	logic CLK;
	logic rstN;
	logic [dataWidth-1:0] DIN;
	logic FETCH;
	logic DECODE;
	logic EXECUTE;
	logic COMMIT;
	logic [dataWidth-1:0] ADDR;
	logic [dataWidth-1:0] DOUT;
	logic RDN;
	logic WRN;

	integer seed = 73;
	int testCount = 0;
	int failCount = 0;
	bit timedOut = 1'b0;
	logic [dataWidth-1:0] pcModel = `CORE_RESET_VECTOR; // expected fetch address.

	clockGen clk0 (.CLK(CLK));

	core dut0 (
		.CLK(CLK),
		.rstN(rstN),
		.DIN(DIN),
		.FETCH(FETCH),
		.DECODE(DECODE),
		.EXECUTE(EXECUTE),
		.COMMIT(COMMIT),
		.ADDR(ADDR),
		.DOUT(DOUT),
		.RDN(RDN),
		.WRN(WRN)
	);

	function automatic bit busMatches(input int want);
		case (want)
			waitFetch: return FETCH && !RDN;
			waitRead: return EXECUTE && !RDN;
			default: return !WRN;
		endcase
	endfunction

	// memory answers with junk on DIN while nothing is asked.
	task automatic waitBus(input int want, input string testName, input string what,
			output bit seen);
		int cycles;
		seen = 1'b0;
		cycles = 0;
		while (!seen && cycles < waitLimit) begin
			@(posedge CLK);
			#driveDelay;
			cycles++;
			if (busMatches(want)) begin
				seen = 1'b1;
			end else begin
				DIN = $random(seed);
			end
		end
		if (!seen) begin
			$display("TIMEOUT in %s: no %s seen within %0d cycles", testName, what, waitLimit);
			timedOut = 1'b1;
		end
	endtask

	task automatic checkValue(input string testName, input string what,
			input logic [dataWidth-1:0] expected, input logic [dataWidth-1:0] actual,
			inout bit ok);
		assert (actual === expected) else begin
			$display("CHECK FAILED %s %s: expected %h, actual %h",
				testName, what, expected, actual);
			ok = 1'b0;
		end
	endtask

	task automatic runCase(input string kind, input string testName,
			input logic [dataWidth-1:0] instr, input logic [dataWidth-1:0] extra,
			input logic [dataWidth-1:0] expAddr, input logic [dataWidth-1:0] expData);
		bit ok;
		bit seen;
		ok = 1'b1;
		waitBus(waitFetch, testName, "instruction fetch", seen);
		if (seen) begin
			checkValue(testName, "fetch address", pcModel, ADDR, ok);
			DIN = instr; // latched at the end of FETCH.
			if (kind == "st") begin
				waitBus(waitWrite, testName, "store write", seen);
				if (seen) begin
					checkValue(testName, "store address", expAddr, ADDR, ok);
					checkValue(testName, "store data", expData, DOUT, ok);
				end
			end else if (kind == "ld" || kind == "here") begin
				waitBus(waitRead, testName, "data read in EXECUTE", seen);
				if (seen) begin
					checkValue(testName, "read address", expAddr, ADDR, ok);
					DIN = extra;
				end
			end
		end
		if (kind == "here") begin
			pcModel = pcModel + 2 * `CORE_PC_STEP; // literal word skipped.
		end else begin
			pcModel = pcModel + `CORE_PC_STEP;
		end
		testCount++;
		if (!seen || !ok) begin
			failCount++;
			$display("FAIL %s", testName);
		end else begin
			$display("PASS %s", testName);
		end
	endtask

	initial begin
		int fd;
		int fields;
		logic [8*128-1:0] line;
		string kind;
		string name;
		logic [dataWidth-1:0] instr;
		logic [dataWidth-1:0] extra;
		logic [dataWidth-1:0] expAddr;
		logic [dataWidth-1:0] expData;
		rstN = 1'b0;
		DIN = '0;
		repeat (resetCycles) @(posedge CLK);
		#driveDelay;
		rstN = 1'b1;
		fd = $fopen("test/instruction_cases.txt", "r");
		if (fd == 0) begin
			$display("could not open test/instruction_cases.txt");
		end else begin
			while (!timedOut && !$feof(fd)) begin
				line = '0;
				if ($fgets(line, fd) != 0) begin
					fields = $sscanf(line, "%s %h %h %h %h %s", kind, instr, extra,
						expAddr, expData, name);
					if (fields == 6) begin
						runCase(kind, name, instr, extra, expAddr, expData);
					end
				end
			end
			$fclose(fd);
		end
		$display("%0d tests run, %0d passed, %0d failed",
			testCount, testCount - failCount, failCount);
		if (failCount == 0 && testCount > 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// File: test/core_sva.sv
`timescale 1ns/1ps

module coreSva (
	input logic CLK,
	input logic rstN,
	input logic FETCH,
	input logic DECODE,
	input logic EXECUTE,
	input logic COMMIT,
	input logic RDN,
	input logic WRN
);

	// one phase pin at a time once running.
	phaseOneHot: assert property (@(posedge CLK) disable iff (!rstN)
		$past(rstN) |-> $onehot({FETCH, DECODE, EXECUTE, COMMIT}))
		else $error("phase pins are not one-hot after reset");

	phaseOrder: assert property (@(posedge CLK) disable iff (!rstN)
		(FETCH |=> DECODE) and (DECODE |=> EXECUTE) and
		(EXECUTE |=> COMMIT) and (COMMIT |=> FETCH))
		else $error("phases left the FETCH, DECODE, EXECUTE, COMMIT order");

	strobesExclusive: assert property (@(posedge CLK) disable iff (!rstN)
		!(!RDN && !WRN))
		else $error("RDN and WRN are low together");

	writeInExecute: assert property (@(posedge CLK) disable iff (!rstN)
		!WRN |-> EXECUTE)
		else $error("WRN is low outside EXECUTE");

endmodule

bind core coreSva sva0 (
	.CLK(CLK),
	.rstN(rstN),
	.FETCH(FETCH),
	.DECODE(DECODE),
	.EXECUTE(EXECUTE),
	.COMMIT(COMMIT),
	.RDN(RDN),
	.WRN(WRN)
);

// File: test/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
	parameter int periodNs = 100
) (
	output logic CLK
);

	initial begin
		CLK = 1'b0;
	end

	always #(periodNs / 2) CLK = ~CLK; // half period high, half low.

endmodule

// File: hdl/core.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module core (
	input  logic                        CLK,
	input  logic                        rstN,
	input  logic [`CORE_DATA_WIDTH-1:0] DIN,
	output logic                        FETCH,
	output logic                        DECODE,
	output logic                        EXECUTE,
	output logic                        COMMIT,
	output logic [`CORE_DATA_WIDTH-1:0] ADDR,
	output logic [`CORE_DATA_WIDTH-1:0] DOUT,
	output logic                        RDN,
	output logic                        WRN
);
	import isaPkg::*;
	import busPkg::*;

	localparam logic [`CORE_DATA_WIDTH-1:0] pcStep = `CORE_PC_STEP;

	corePhase    phase;
	decodedInstr dec;
	busReq       bus;
	logic        seqRstN;
	logic        regWriteEn;
	logic [`CORE_DATA_WIDTH-1:0] pc;
	logic [`CORE_DATA_WIDTH-1:0] ir;
	logic [`CORE_DATA_WIDTH-1:0] loadData;
	logic [`CORE_DATA_WIDTH-1:0] pcAdvance;
	logic [`CORE_DATA_WIDTH-1:0] fetchAddr;
	logic [`CORE_DATA_WIDTH-1:0] readDataA;
	logic [`CORE_DATA_WIDTH-1:0] readDataB;
	logic [`CORE_DATA_WIDTH-1:0] aluB;
	logic [`CORE_DATA_WIDTH-1:0] aluResult;
	logic [`CORE_DATA_WIDTH-1:0] writeData;

	// sequencer leaves reset one cycle late, so the first live phase is FETCH.
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			seqRstN <= 1'b0;
		end else begin
			seqRstN <= 1'b1;
		end
	end

	phaseSequencer seq0 (.CLK(CLK), .rstN(seqRstN), .phase(phase));

	instructionDecoder dec0 (.instr(ir), .dec(dec));

	registerFile regs0 (
		.CLK(CLK),
		.rstN(rstN),
		.readAddrA(dec.regA),
		.readAddrB(dec.regB),
		.readDataA(readDataA),
		.readDataB(readDataB),
		.writeEn(regWriteEn),
		.writeAddr(dec.regA),
		.writeData(writeData)
	);

	assign aluB = dec.useImm ? dec.imm : readDataB; // immediate or register operand.

	aluUnit alu0 (.op(dec.op), .a(readDataA), .b(aluB), .result(aluResult));

	assign writeData  = (dec.isLoad || dec.isHere) ? loadData : aluResult;
	assign regWriteEn = seqRstN && (phase == phCommit) && dec.writesReg;

	// HERE skips its literal word.
	assign pcAdvance = dec.isHere ? pc + (pcStep << 1) : pc + pcStep;
	assign fetchAddr = seqRstN ? pcAdvance : pc;

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			pc <= `CORE_RESET_VECTOR;
		end else if (seqRstN && phase == phCommit) begin
			pc <= pcAdvance;
		end
	end

	always_ff @(posedge CLK) begin
		if (phase == phFetch) begin
			ir <= DIN; // instruction at end of FETCH.
		end
		if (phase == phExecute) begin
			loadData <= DIN; // LD and HERE data.
		end
	end

	// request is set up at the edge that starts its phase.
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			bus <= busIdle;
		end else begin
			bus <= busIdle;
			if (!seqRstN || phase == phCommit) begin
				bus.addr <= fetchAddr;
				bus.rdN  <= 1'b0;
			end else if (phase == phDecode) begin
				if (dec.isLoad) begin
					bus.addr <= readDataB;
					bus.rdN  <= 1'b0;
				end else if (dec.isHere) begin
					bus.addr <= pc + pcStep;
					bus.rdN  <= 1'b0;
				end else if (dec.isStore) begin
					bus.addr <= readDataB;
					bus.dout <= readDataA;
					bus.wrN  <= 1'b0;
				end
			end
		end
	end

	assign ADDR = bus.addr;
	assign DOUT = bus.dout;
	assign RDN  = bus.rdN;
	assign WRN  = bus.wrN;

	assign FETCH   = seqRstN && (phase == phFetch);
	assign DECODE  = seqRstN && (phase == phDecode);
	assign EXECUTE = seqRstN && (phase == phExecute);
	assign COMMIT  = seqRstN && (phase == phCommit);

endmodule

// File: hdl/aluUnit.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module aluUnit (
	input  isaPkg::aluOp                op,
	input  logic [`CORE_DATA_WIDTH-1:0] a,
	input  logic [`CORE_DATA_WIDTH-1:0] b,
	output logic [`CORE_DATA_WIDTH-1:0] result
);
	import isaPkg::*;

	// a is the destination value, b the operand.
	always_comb begin
		case (op)
			opAdd: begin
				result = a + b; // wraps at 16 bits.
			end
			opSub: begin
				result = a - b;
			end
			opAnd: begin
				result = a & b;
			end
			opOr: begin
				result = a | b;
			end
			opXor: begin
				result = a ^ b;
			end
			default: begin
				result = b; // move.
			end
		endcase
	end

endmodule

// File: hdl/registerFile.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module registerFile (
	input  logic                                CLK,
	input  logic                                rstN,
	input  logic [$clog2(`CORE_REG_COUNT)-1:0] readAddrA,
	input  logic [$clog2(`CORE_REG_COUNT)-1:0] readAddrB,
	output logic [`CORE_DATA_WIDTH-1:0]        readDataA,
	output logic [`CORE_DATA_WIDTH-1:0]        readDataB,
	input  logic                                writeEn,
	input  logic [$clog2(`CORE_REG_COUNT)-1:0] writeAddr,
	input  logic [`CORE_DATA_WIDTH-1:0]        writeData
);

	logic [`CORE_DATA_WIDTH-1:0] regs [`CORE_REG_COUNT];

	// reads are combinational.
	assign readDataA = regs[readAddrA];
	assign readDataB = regs[readAddrB];

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			for (int i = 0; i < `CORE_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn) begin
			regs[writeAddr] <= writeData; // visible from the next cycle.
		end
	end

endmodule

// File: hdl/instructionDecoder.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module instructionDecoder (
	input  logic [`CORE_DATA_WIDTH-1:0] instr,
	output isaPkg::decodedInstr         dec
);
	import isaPkg::*;

	instrGroup group;
	aluMode    aMode;
	lsMode     lMode;
	aluOp      rawOp;
	aluOp      op;

	assign group = instrGroup'(instr[15:14]);
	assign aMode = aluMode'(instr[9:8]);
	assign lMode = lsMode'(instr[11]);
	assign rawOp = aluOp'(instr[13:10]);

	always_comb begin
		case (rawOp)
			opAdd, opSub, opAnd, opOr, opXor: op = rawOp;
			default: op = opMov; // unlisted codes act as MOV.
		endcase
	end

	always_comb begin
		dec = '0; // no-op unless a group below claims it.
		case (group)
			groupAlu: begin
				dec.isAlu     = 1'b1;
				dec.writesReg = 1'b1;
				dec.op        = op;
				case (aMode)
					modeRegaS8: begin
						dec.regA   = regRa;
						dec.useImm = 1'b1;
						dec.imm    = {{(`CORE_DATA_WIDTH-8){instr[7]}}, instr[7:0]};
					end
					modeRegaU8: begin
						dec.regA   = regRa;
						dec.useImm = 1'b1;
						dec.imm    = {{(`CORE_DATA_WIDTH-8){1'b0}}, instr[7:0]};
					end
					modeRegU4: begin
						dec.regA   = instr[7:4];
						dec.useImm = 1'b1;
						dec.imm    = {{(`CORE_DATA_WIDTH-4){1'b0}}, instr[3:0]};
					end
					default: begin
						dec.regA = instr[7:4]; // register to register.
						dec.regB = instr[3:0];
					end
				endcase
			end
			groupLoadStore: begin
				if (!instr[13]) begin
					dec.regA = instr[7:4];
					if (lMode == modeLsHere) begin
						dec.isHere    = 1'b1; // literal from pc+2.
						dec.writesReg = 1'b1;
					end else begin
						dec.regB = instr[3:0]; // address register.
						if (instr[12]) begin
							dec.isStore = 1'b1;
						end else begin
							dec.isLoad    = 1'b1;
							dec.writesReg = 1'b1;
						end
					end
				end
			end
			groupReserved2, groupReserved3: begin
			end
		endcase
	end

endmodule

// File: hdl/phaseSequencer.sv
`timescale 1ns/1ps

module phaseSequencer (
	input  logic             CLK,
	input  logic             rstN,
	output busPkg::corePhase phase
);
	import busPkg::*;

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			phase <= phFetch; // parked until released.
		end else begin
			case (phase)
				phFetch: begin
					phase <= phDecode;
				end
				phDecode: begin
					phase <= phExecute;
				end
				phExecute: begin
					phase <= phCommit;
				end
				default: begin
					phase <= phFetch; // wrap after commit.
				end
			endcase
		end
	end

endmodule

// File: hdl/busPkg.sv
`include "core_settings.svh"

package busPkg;

	// one phase per clock, four per instruction.
	typedef enum logic [1:0] {
		phFetch   = 2'd0,
		phDecode  = 2'd1,
		phExecute = 2'd2,
		phCommit  = 2'd3
	} corePhase;

	typedef struct packed {
		logic [`CORE_DATA_WIDTH-1:0] addr;
		logic [`CORE_DATA_WIDTH-1:0] dout;
		logic rdN;
		logic wrN;
	} busReq;

	// bus parked with both strobes high.
	localparam busReq busIdle = '{addr: '0, dout: '0, rdN: 1'b1, wrN: 1'b1};

endpackage

// File: hdl/isaPkg.sv
`include "core_settings.svh"

package isaPkg;

	// instruction group, bits 15:14.
	typedef enum logic [1:0] {
		groupAlu       = 2'b00,
		groupLoadStore = 2'b01,
		groupReserved2 = 2'b10, // executes as a no-op.
		groupReserved3 = 2'b11
	} instrGroup;

	// alu operation, bits 13:10.
	typedef enum logic [3:0] {
		opMov = 4'h0,
		opAdd = 4'h1,
		opSub = 4'h2,
		opAnd = 4'h3,
		opOr  = 4'h4,
		opXor = 4'h5
	} aluOp;

	// alu addressing mode, bits 9:8.
	typedef enum logic [1:0] {
		modeRegaS8 = 2'b00,
		modeRegaU8 = 2'b01,
		modeRegU4  = 2'b10,
		modeRegReg = 2'b11
	} aluMode;

	// load/store mode, bit 11.
	typedef enum logic {
		modeLsRegReg = 1'b0,
		modeLsHere   = 1'b1
	} lsMode;

	// accumulator index.
	localparam logic [3:0] regRa = 4'hf;

	typedef struct packed {
		logic isAlu;
		logic isLoad;
		logic isStore;
		logic isHere;
		aluOp op;
		logic [3:0] regA; // destination or data register.
		logic [3:0] regB; // operand or address register.
		logic useImm;
		logic [`CORE_DATA_WIDTH-1:0] imm; // already extended.
		logic writesReg;
	} decodedInstr;

endpackage

// File: include/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// data and address bus width.
`define CORE_DATA_WIDTH 16

// register count, RA is the last one.
`define CORE_REG_COUNT 16

// pc value after reset.
`define CORE_RESET_VECTOR 16'h0000

// byte step per instruction word.
`define CORE_PC_STEP 2

`endif
